//--- u2_pkg.sv
/* Shared definitions for the control-plane core: bus types, Wishbone
   address map, settings register addresses and interrupt positions */

package u2_pkg;

   // Vector widths
   typedef logic [15:0] wb_adr_t;
   typedef logic [31:0] wb_dat_t;
   typedef logic [7:0]  set_addr_t;

   localparam int NUM_IRQ     = 8;
   localparam int TIMER_WIDTH = 32;

   typedef logic [NUM_IRQ-1:0] irq_vec_t;

   // Wishbone request and response, master view
   typedef struct packed {
      wb_adr_t adr;
      wb_dat_t dat;
      logic    we;
      logic    stb;
   } wb_req_t;

   typedef struct packed {
      wb_dat_t dat;
      logic    ack;
      logic    err;
   } wb_rsp_t;

   // One settings bus write
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      wb_dat_t   data;
   } set_bus_t;

   // Region decode on address bits 15:14
   typedef enum logic [1:0] {
      SETTINGS = 2'd0,
      READBACK = 2'd1,
      PIC      = 2'd2,
      NONE     = 2'd3
   } wb_slave_e;

   localparam wb_adr_t SETTINGS_BASE = 16'h0000;
   localparam wb_adr_t READBACK_BASE = 16'h4000;
   localparam wb_adr_t PIC_BASE      = 16'h8000;
   localparam wb_adr_t UNMAPPED_BASE = 16'hC000;

   // Settings register addresses
   localparam set_addr_t SR_CLOCK_CTRL = 8'd0;
   localparam set_addr_t SR_LED_SW     = 8'd3;
   localparam set_addr_t SR_PHY        = 8'd4;
   localparam set_addr_t SR_LED_SRC    = 8'd8;
   localparam set_addr_t SR_SIMTIMER   = 8'd198;

   localparam logic [7:0] LED_SRC_RESET = 8'h1E;
   localparam wb_dat_t    COMPAT_NUM    = 32'd3;

   // Interrupt line positions
   localparam int IRQ_ONETIME  = 0;
   localparam int IRQ_PERIODIC = 1;

endpackage

//--- wb_intercon.sv
/* Single-master Wishbone decoder, routes each access to one of three
   slaves by address bits 15:14 and answers unmapped space with err */

module wb_intercon (
   input  logic            wb_clk,
   input  logic            wb_rst,
   input  u2_pkg::wb_req_t m_req_i,
   output u2_pkg::wb_rsp_t m_rsp_o,
   output u2_pkg::wb_req_t set_req_o,
   output u2_pkg::wb_req_t rb_req_o,
   output u2_pkg::wb_req_t pic_req_o,
   input  u2_pkg::wb_rsp_t set_rsp_i,
   input  u2_pkg::wb_rsp_t rb_rsp_i,
   input  u2_pkg::wb_rsp_t pic_rsp_i
);

   u2_pkg::wb_slave_e region;
   logic              err_q;

   assign region = u2_pkg::wb_slave_e'(m_req_i.adr[15:14]);

   // Address, data and we go to all slaves, only the strobe is steered
   always_comb begin
      set_req_o     = m_req_i;
      rb_req_o      = m_req_i;
      pic_req_o     = m_req_i;
      set_req_o.stb = m_req_i.stb && (region == u2_pkg::SETTINGS);
      rb_req_o.stb  = m_req_i.stb && (region == u2_pkg::READBACK);
      pic_req_o.stb = m_req_i.stb && (region == u2_pkg::PIC);
   end

   // Error responder for the unmapped region
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         err_q <= 1'b0;
      end else begin
         err_q <= m_req_i.stb && (region == u2_pkg::NONE) && !err_q;
      end
   end

   // Read data only counts while its slave acks
   assign m_rsp_o.dat = ({32{set_rsp_i.ack}} & set_rsp_i.dat) |
                        ({32{rb_rsp_i.ack}}  & rb_rsp_i.dat)  |
                        ({32{pic_rsp_i.ack}} & pic_rsp_i.dat);
   assign m_rsp_o.ack = set_rsp_i.ack | rb_rsp_i.ack | pic_rsp_i.ack;
   assign m_rsp_o.err = err_q | set_rsp_i.err | rb_rsp_i.err | pic_rsp_i.err;

   a_one_response: assert property (@(posedge wb_clk) disable iff (wb_rst)
      $onehot0({set_rsp_i.ack, rb_rsp_i.ack, pic_rsp_i.ack, err_q}));

endmodule

//--- settings_bus.sv
/* Settings bus master, turns each Wishbone write into a one-cycle
   strobe with the register address and data */

module settings_bus (
   input  logic             wb_clk,
   input  logic             wb_rst,
   input  u2_pkg::wb_req_t  req_i,
   output u2_pkg::wb_rsp_t  rsp_o,
   output u2_pkg::set_bus_t set_o
);

   logic ack_q;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         ack_q     <= 1'b0;
         set_o.stb <= 1'b0;
      end else begin
         ack_q     <= req_i.stb && !ack_q;
         // Strobe lines up with the ack
         set_o.stb <= req_i.stb && req_i.we && !ack_q;
      end
   end

   // Word address, byte offset dropped
   always_ff @(posedge wb_clk) begin
      set_o.addr <= req_i.adr[9:2];
      set_o.data <= req_i.dat;
   end

   assign rsp_o.dat = '0;
   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;

endmodule

//--- board_ctrl_regs.sv
/* Board control settings, clock control lines, PHY reset and the
   LED registers with the hardware/software LED mix */

module board_ctrl_regs (
   input  logic             wb_clk,
   input  logic             wb_rst,
   input  u2_pkg::set_bus_t set_i,
   input  logic [7:0]       led_hw_i,
   output logic [7:0]       leds_o,
   output logic [4:0]       clk_ctrl_o,
   output logic             phy_reset_o
);

   logic [7:0] led_sw;
   logic [7:0] led_src;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         clk_ctrl_o  <= '0;
         led_sw      <= '0;
         led_src     <= u2_pkg::LED_SRC_RESET;
         phy_reset_o <= 1'b0;
      end else if (set_i.stb) begin
         if (set_i.addr == u2_pkg::SR_CLOCK_CTRL) begin
            clk_ctrl_o <= set_i.data[4:0];
         end
         if (set_i.addr == u2_pkg::SR_LED_SW) begin
            led_sw <= set_i.data[7:0];
         end
         if (set_i.addr == u2_pkg::SR_PHY) begin
            phy_reset_o <= set_i.data[0];
         end
         if (set_i.addr == u2_pkg::SR_LED_SRC) begin
            led_src <= set_i.data[7:0];
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // LED mix
   // Source bit 1 selects the hardware LED, 0 the software value

   assign leds_o = (led_src & led_hw_i) | (~led_src & led_sw);

endmodule

//--- simple_timer.sv
/* Settings-loaded timer with a one-shot and a periodic interrupt pulse */

module simple_timer #(
   parameter u2_pkg::set_addr_t TIMER_BASE = 8'd198,
   parameter int                TIMER_W    = 32
) (
   input  logic             wb_clk,
   input  logic             wb_rst,
   input  u2_pkg::set_bus_t set_i,
   output logic             onetime_int_o,
   output logic             periodic_int_o
);

   logic [TIMER_W-1:0] onetime_cnt;
   logic [TIMER_W-1:0] period;
   logic [TIMER_W-1:0] period_cnt;
   logic               wr_onetime;
   logic               wr_period;

   assign wr_onetime = set_i.stb && (set_i.addr == TIMER_BASE);
   assign wr_period  = set_i.stb && (set_i.addr == u2_pkg::set_addr_t'(TIMER_BASE + 1));

   // One-shot, a load of 0 cancels a pending shot
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         onetime_cnt   <= '0;
         onetime_int_o <= 1'b0;
      end else if (wr_onetime) begin
         onetime_cnt   <= set_i.data[TIMER_W-1:0];
         onetime_int_o <= 1'b0;
      end else begin
         onetime_int_o <= (onetime_cnt == 1);
         if (onetime_cnt != 0) begin
            onetime_cnt <= onetime_cnt - 1'b1;
         end
      end
   end

   // Periodic, restarts from the full period on every fire
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         period         <= '0;
         period_cnt     <= '0;
         periodic_int_o <= 1'b0;
      end else if (wr_period) begin
         period         <= set_i.data[TIMER_W-1:0];
         period_cnt     <= set_i.data[TIMER_W-1:0];
         periodic_int_o <= 1'b0;
      end else if (period_cnt == 1) begin
         period_cnt <= period;
         // a period of 1 fires every other cycle
         periodic_int_o <= !periodic_int_o;
      end else begin
         periodic_int_o <= 1'b0;
         if (period_cnt != 0) begin
            period_cnt <= period_cnt - 1'b1;
         end
      end
   end

   a_single_pulse: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (onetime_int_o |=> !onetime_int_o) and (periodic_int_o |=> !periodic_int_o));

endmodule

//--- pic.sv
/* Edge-triggered interrupt controller with enable mask, pending
   register and a lowest-index priority encoder on Wishbone */

module pic #(
   parameter int N_IRQ = 8
) (
   input  logic             wb_clk,
   input  logic             wb_rst,
   input  u2_pkg::wb_req_t  req_i,
   output u2_pkg::wb_rsp_t  rsp_o,
   input  u2_pkg::irq_vec_t irq_i,
   output logic             int_o
);

   logic [N_IRQ-1:0] irq_d;
   logic [N_IRQ-1:0] edges;
   logic [N_IRQ-1:0] mask;
   logic [N_IRQ-1:0] pending;
   logic [N_IRQ-1:0] active;
   logic [N_IRQ-1:0] clr;
   logic [1:0]       word;
   logic             ack_q;
   logic             wr;
   u2_pkg::wb_dat_t  prio;
   u2_pkg::wb_dat_t  rd_data;
   u2_pkg::wb_dat_t  dat_q;

   assign edges  = irq_i[N_IRQ-1:0] & ~irq_d;
   assign active = pending & mask;
   assign int_o  = |active;
   assign word   = req_i.adr[3:2];
   assign wr     = req_i.stb && req_i.we && !ack_q;
   assign clr    = (wr && word == 2'd1) ? req_i.dat[N_IRQ-1:0] : '0;

   //////////////////////////////////////////////////////////////////////
   // Edge capture, a new edge beats a clear in the same cycle

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         irq_d   <= '0;
         pending <= '0;
         mask    <= '0;
         ack_q   <= 1'b0;
      end else begin
         irq_d   <= irq_i[N_IRQ-1:0];
         pending <= (pending & ~clr) | edges;
         ack_q   <= req_i.stb && !ack_q;
         if (wr && word == 2'd0) begin
            mask <= req_i.dat[N_IRQ-1:0];
         end
      end
   end

   // Lowest active line wins, bit 31 flags none
   always_comb begin
      prio = 32'h8000_0000;
      for (int i = N_IRQ - 1; i >= 0; i--) begin
         if (active[i]) begin
            prio = u2_pkg::wb_dat_t'(i);
         end
      end
   end

   always_comb begin
      case (word)
         2'd0:    rd_data = u2_pkg::wb_dat_t'(mask);
         2'd1:    rd_data = u2_pkg::wb_dat_t'(pending);
         2'd2:    rd_data = prio;
         default: rd_data = '0;
      endcase
   end

   always_ff @(posedge wb_clk) begin
      dat_q <= rd_data;
   end

   assign rsp_o.dat = dat_q;
   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;

endmodule

//--- status_readback.sv
/* Read-only status window, compatibility number, free-running cycle
   counter and the raw interrupt lines */

module status_readback (
   input  logic             wb_clk,
   input  logic             wb_rst,
   input  u2_pkg::wb_req_t  req_i,
   output u2_pkg::wb_rsp_t  rsp_o,
   input  u2_pkg::irq_vec_t irq_i
);

   u2_pkg::wb_dat_t cycle_count;
   u2_pkg::wb_dat_t dat_q;
   logic            ack_q;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         cycle_count <= '0;
         ack_q       <= 1'b0;
      end else begin
         cycle_count <= cycle_count + 1'b1;
         // Writes get the same ack and change nothing
         ack_q       <= req_i.stb && !ack_q;
      end
   end

   always_ff @(posedge wb_clk) begin
      case (req_i.adr[5:2])
         4'd0:    dat_q <= u2_pkg::COMPAT_NUM;
         4'd1:    dat_q <= cycle_count;
         4'd2:    dat_q <= u2_pkg::wb_dat_t'(irq_i);
         default: dat_q <= '0;
      endcase
   end

   assign rsp_o.dat = dat_q;
   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;

endmodule

//--- u2_ctrl_core.sv
/* Control-plane core, Wishbone interconnect with the settings bus,
   board control, timer, interrupt controller and status window */

module u2_ctrl_core (
   input  logic            wb_clk,
   input  logic            wb_rst,
   input  u2_pkg::wb_req_t wb_req_i,
   output u2_pkg::wb_rsp_t wb_rsp_o,
   input  logic [5:0]      ext_irq_i,
   input  logic [7:0]      led_hw_i,
   output logic [7:0]      leds_o,
   output logic [4:0]      clk_ctrl_o,
   output logic            phy_resetn_o,
   output logic            int_o
);

   u2_pkg::wb_req_t  set_req, rb_req, pic_req;
   u2_pkg::wb_rsp_t  set_rsp, rb_rsp, pic_rsp;
   u2_pkg::set_bus_t set_bus;
   u2_pkg::irq_vec_t irq_vec;
   logic             phy_reset;
   logic             onetime_int;
   logic             periodic_int;

   //////////////////////////////////////////////////////////////////////
   // Wishbone fabric

   wb_intercon intercon0 (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .m_req_i(wb_req_i), .m_rsp_o(wb_rsp_o),
      .set_req_o(set_req), .rb_req_o(rb_req), .pic_req_o(pic_req),
      .set_rsp_i(set_rsp), .rb_rsp_i(rb_rsp), .pic_rsp_i(pic_rsp)
   );

   settings_bus settings0 (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(set_req), .rsp_o(set_rsp), .set_o(set_bus)
   );

   //////////////////////////////////////////////////////////////////////
   // Settings consumers

   board_ctrl_regs board0 (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_bus),
      .led_hw_i(led_hw_i), .leds_o(leds_o),
      .clk_ctrl_o(clk_ctrl_o), .phy_reset_o(phy_reset)
   );

   // PHY reset pin is active low
   assign phy_resetn_o = ~phy_reset;

   simple_timer #(
      .TIMER_BASE(u2_pkg::SR_SIMTIMER),
      .TIMER_W(u2_pkg::TIMER_WIDTH)
   ) timer0 (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_bus),
      .onetime_int_o(onetime_int), .periodic_int_o(periodic_int)
   );

   //////////////////////////////////////////////////////////////////////
   // Interrupts and status

   always_comb begin
      irq_vec                       = {ext_irq_i, 2'b00};
      irq_vec[u2_pkg::IRQ_ONETIME]  = onetime_int;
      irq_vec[u2_pkg::IRQ_PERIODIC] = periodic_int;
   end

   pic #(
      .N_IRQ(u2_pkg::NUM_IRQ)
   ) pic0 (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(pic_req), .rsp_o(pic_rsp), .irq_i(irq_vec), .int_o(int_o)
   );

   status_readback readback0 (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(rb_req), .rsp_o(rb_rsp), .irq_i(irq_vec)
   );

endmodule

//--- tb_u2_ctrl_core.sv
/* Testbench for the control-plane core, random settings writes, bus
   decode, interrupt controller and timer checked against a local model */

module tb_u2_ctrl_core;

   localparam int N_ITER    = 200;
   localparam int N_IRQ_RUN = 20;
   localparam int K_GAP     = 5;
   localparam int CYCLE_MAX = 2000 + 50 * N_ITER;

   logic            wb_clk;
   logic            wb_rst;
   u2_pkg::wb_req_t req;
   u2_pkg::wb_rsp_t rsp;
   logic [5:0]      ext_irq;
   logic [7:0]      led_hw;
   logic [7:0]      leds;
   logic [4:0]      clk_ctrl;
   logic            phy_resetn;
   logic            int_o;

   integer seed;
   int     cycles = 0;
   int     checks = 0;
   int     errors = 0;

   // Model state
   logic [7:0] m_led_sw;
   logic [7:0] m_led_src;
   logic [4:0] m_clk_ctrl;
   logic       m_phy_reset;
   logic [7:0] m_pend;
   logic [7:0] m_mask;

   u2_ctrl_core dut0 (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_req_i(req), .wb_rsp_o(rsp),
      .ext_irq_i(ext_irq), .led_hw_i(led_hw), .leds_o(leds),
      .clk_ctrl_o(clk_ctrl), .phy_resetn_o(phy_resetn), .int_o(int_o)
   );

   initial wb_clk = 1'b0;
   always #2 wb_clk = ~wb_clk;

   always @(posedge wb_clk) begin
      cycles++;
      if (cycles >= CYCLE_MAX) begin
         abort_run("Cycle limit reached before the tests finished");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("Simulation finished: FAIL");
      $finish;
   endtask

   task automatic compare(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // Holds stb until ack or err, then leaves one idle cycle
   task automatic bus_access(input u2_pkg::wb_adr_t adr, input u2_pkg::wb_dat_t dat,
                             input logic we, output u2_pkg::wb_dat_t rdata,
                             output logic got_ack, output logic got_err);
      int waited;
      waited  = 0;
      got_ack = 1'b0;
      got_err = 1'b0;
      rdata   = '0;
      @(negedge wb_clk);
      req.adr = adr;
      req.dat = dat;
      req.we  = we;
      req.stb = 1'b1;
      while (!got_ack && !got_err && waited < 4) begin
         @(negedge wb_clk);
         waited++;
         got_ack = rsp.ack;
         got_err = rsp.err;
         rdata   = rsp.dat;
      end
      req.stb = 1'b0;
      req.we  = 1'b0;
      if (!got_ack && !got_err) begin
         abort_run("Bus access got neither ack nor err within 4 cycles");
      end else begin
         @(negedge wb_clk);
      end
   endtask

   task automatic write_word(input u2_pkg::wb_adr_t adr, input u2_pkg::wb_dat_t dat);
      u2_pkg::wb_dat_t rd;
      logic            a;
      logic            e;
      bus_access(adr, dat, 1'b1, rd, a, e);
      compare("wb ack on write", a, 1'b1);
   endtask

   task automatic read_word(input u2_pkg::wb_adr_t adr, output u2_pkg::wb_dat_t rd);
      logic a;
      logic e;
      bus_access(adr, '0, 1'b0, rd, a, e);
      compare("wb ack on read", a, 1'b1);
   endtask

   function automatic u2_pkg::wb_adr_t setting_adr(input u2_pkg::set_addr_t sa);
      return {6'd0, sa, 2'b00};
   endfunction

   // Hardware bit where the source bit is set, software bit otherwise
   function automatic logic [7:0] mixed_leds();
      logic [7:0] mix;
      for (int i = 0; i < 8; i++) begin
         mix[i] = m_led_src[i] ? led_hw[i] : m_led_sw[i];
      end
      return mix;
   endfunction

   // First set bit from the bottom, bit 31 stays set while none is found
   function automatic u2_pkg::wb_dat_t lowest_active(input logic [7:0] act);
      u2_pkg::wb_dat_t idx;
      idx = 32'h8000_0000;
      for (int i = 0; i < 8; i++) begin
         if (act[i] && idx[31]) begin
            idx = i;
         end
      end
      return idx;
   endfunction

   task automatic check_board();
      compare("leds_o", leds, mixed_leds());
      compare("clk_ctrl_o", clk_ctrl, m_clk_ctrl);
      compare("phy_resetn_o", phy_resetn, !m_phy_reset);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      u2_pkg::wb_dat_t   rd;
      u2_pkg::wb_dat_t   c0;
      u2_pkg::wb_dat_t   c1;
      u2_pkg::wb_dat_t   wdat;
      u2_pkg::set_addr_t sa;
      logic              a;
      logic              e;
      logic [5:0]        prev_ext;
      logic [7:0]        clr;
      int                kind;
      int                n;
      int                p;

      seed        = 32'h9b962a13;
      wb_rst      = 1'b1;
      req         = '0;
      ext_irq     = '0;
      led_hw      = $random(seed);
      m_led_sw    = '0;
      m_led_src   = u2_pkg::LED_SRC_RESET;
      m_clk_ctrl  = '0;
      m_phy_reset = 1'b0;
      m_pend      = '0;
      m_mask      = '0;
      prev_ext    = '0;
      repeat (5) @(posedge wb_clk);
      @(negedge wb_clk);
      wb_rst = 1'b0;

      // State after reset
      @(negedge wb_clk);
      check_board();
      compare("int_o", int_o, 1'b0);
      read_word(u2_pkg::READBACK_BASE, rd);
      compare("compat number", rd, u2_pkg::COMPAT_NUM);

      // Random settings writes, unused addresses stay clear of the timer
      for (int i = 0; i < N_ITER; i++) begin
         kind = $unsigned($random(seed)) % 5;
         case (kind)
            0:       sa = u2_pkg::SR_CLOCK_CTRL;
            1:       sa = u2_pkg::SR_LED_SW;
            2:       sa = u2_pkg::SR_PHY;
            3:       sa = u2_pkg::SR_LED_SRC;
            default: sa = 8'd16 + 8'($unsigned($random(seed)) % 180);
         endcase
         wdat = $random(seed);
         @(negedge wb_clk);
         led_hw = $random(seed);
         write_word(setting_adr(sa), wdat);
         if (sa == u2_pkg::SR_CLOCK_CTRL) m_clk_ctrl = wdat[4:0];
         if (sa == u2_pkg::SR_LED_SW) m_led_sw = wdat[7:0];
         if (sa == u2_pkg::SR_PHY) m_phy_reset = wdat[0];
         if (sa == u2_pkg::SR_LED_SRC) m_led_src = wdat[7:0];
         check_board();
      end

      // Unmapped region and cycle counter
      bus_access(u2_pkg::UNMAPPED_BASE | 16'h0124, '0, 1'b0, rd, a, e);
      compare("wb err on unmapped", e, 1'b1);
      compare("wb ack on unmapped", a, 1'b0);
      read_word(u2_pkg::READBACK_BASE + 16'h4, c0);
      repeat (K_GAP) read_word(u2_pkg::READBACK_BASE, rd);
      read_word(u2_pkg::READBACK_BASE + 16'h4, c1);
      checks++;
      if (!(c1 > c0 && c1 - c0 >= 2 * K_GAP)) begin
         errors++;
         $display("error cycle_count: got %h after %h, expected a rise of at least %h",
                  c1, c0, 2 * K_GAP);
      end

      // External interrupt edges
      m_mask = $random(seed);
      write_word(u2_pkg::PIC_BASE, m_mask);
      read_word(u2_pkg::PIC_BASE, rd);
      compare("pic mask", rd, m_mask);
      for (int i = 0; i < N_IRQ_RUN; i++) begin
         @(negedge wb_clk);
         ext_irq = $random(seed);
         m_pend[7:2] = m_pend[7:2] | (ext_irq & ~prev_ext);
         prev_ext = ext_irq;
         read_word(u2_pkg::PIC_BASE + 16'h4, rd);
         compare("pic pending", rd, m_pend);
         compare("int_o", int_o, |(m_pend & m_mask));
         read_word(u2_pkg::PIC_BASE + 16'h8, rd);
         compare("pic priority", rd, lowest_active(m_pend & m_mask));
         // Timer lines are idle here
         read_word(u2_pkg::READBACK_BASE + 16'h8, rd);
         compare("raw irq lines", rd, {ext_irq, 2'b00});
         if (i % 4 == 3) begin
            clr = $random(seed);
            write_word(u2_pkg::PIC_BASE + 16'h4, clr);
            m_pend = m_pend & ~clr;
            read_word(u2_pkg::PIC_BASE + 16'h4, rd);
            compare("pic pending after clear", rd, m_pend);
         end
      end
      write_word(u2_pkg::PIC_BASE + 16'h4, 32'hFF);
      m_pend = '0;

      // One-shot timer
      n = 20 + $unsigned($random(seed)) % 64;
      write_word(setting_adr(u2_pkg::SR_SIMTIMER), n);
      read_word(u2_pkg::PIC_BASE + 16'h4, rd);
      compare("pending before one-shot", rd, m_pend);
      repeat (n + 10) @(negedge wb_clk);
      m_pend[u2_pkg::IRQ_ONETIME] = 1'b1;
      read_word(u2_pkg::PIC_BASE + 16'h4, rd);
      compare("pending after one-shot", rd, m_pend);
      write_word(u2_pkg::PIC_BASE + 16'h4, 32'h1 << u2_pkg::IRQ_ONETIME);
      m_pend = '0;

      // Periodic timer, fires again after each clear
      p = 16 + $unsigned($random(seed)) % 32;
      write_word(setting_adr(u2_pkg::SR_SIMTIMER + 8'd1), p);
      m_pend[u2_pkg::IRQ_PERIODIC] = 1'b1;
      repeat (2) begin
         repeat (p + 10) @(negedge wb_clk);
         read_word(u2_pkg::PIC_BASE + 16'h4, rd);
         compare("pending with periodic", rd, m_pend);
         write_word(u2_pkg::PIC_BASE + 16'h4, 32'h1 << u2_pkg::IRQ_PERIODIC);
      end
      write_word(setting_adr(u2_pkg::SR_SIMTIMER + 8'd1), 32'd0);
      write_word(u2_pkg::PIC_BASE + 16'h4, 32'h1 << u2_pkg::IRQ_PERIODIC);
      m_pend = '0;
      repeat (3 * p) @(negedge wb_clk);
      read_word(u2_pkg::PIC_BASE + 16'h4, rd);
      compare("pending after periodic off", rd, m_pend);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- build.f
u2_pkg.sv
wb_intercon.sv
settings_bus.sv
board_ctrl_regs.sv
simple_timer.sv
pic.sv
status_readback.sv
u2_ctrl_core.sv
tb_u2_ctrl_core.sv
